/* logic/bus_arbiter.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module bus_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   f_req,
    input  cpu_pkg::mem_req_t      f_cmd,
    input  logic                   d_req,
    input  cpu_pkg::mem_req_t      d_cmd,
    input  logic                   mem_ack,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,
    output logic                   f_ack,
    output logic [`CPU_DATA_W-1:0] f_rdata,
    output logic                   d_ack,
    output logic [`CPU_DATA_W-1:0] d_rdata,
    output logic                   mem_req,
    output cpu_pkg::mem_req_t      mem_cmd
);

    cpu_pkg::bus_state_e state;
    logic                gnt_data;
    logic                gnt_req;

    // request line of whichever side holds the bus
    assign gnt_req = gnt_data ? d_req : f_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= cpu_pkg::b_idle;
            gnt_data <= 1'b0;
            mem_req  <= 1'b0;
            mem_cmd  <= '0;
            f_ack    <= 1'b0;
            d_ack    <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::b_idle: begin
                    // loads and stores go ahead of prefetch
                    if (d_req) begin
                        gnt_data <= 1'b1;
                        mem_cmd  <= d_cmd;
                        state    <= cpu_pkg::b_data;
                    end else if (f_req) begin
                        gnt_data <= 1'b0;
                        mem_cmd  <= f_cmd;
                        state    <= cpu_pkg::b_fetch;
                    end
                end

                cpu_pkg::b_fetch, cpu_pkg::b_data: begin
                    if (!mem_req && !mem_ack) begin
                        mem_req <= 1'b1;
                    end else if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                        if (gnt_data) begin
                            d_ack   <= 1'b1;
                            d_rdata <= mem_rdata;
                        end else begin
                            f_ack   <= 1'b1;
                            f_rdata <= mem_rdata;
                        end
                        state <= cpu_pkg::b_release;
                    end
                end

                cpu_pkg::b_release: begin
                    // both handshakes back to idle before the next grant
                    if (!mem_ack && !gnt_req) begin
                        f_ack <= 1'b0;
                        d_ack <= 1'b0;
                        state <= cpu_pkg::b_idle;
                    end
                end

                default: begin
                    state <= cpu_pkg::b_idle;
                end
            endcase
        end
    end

endmodule

/* logic/control_unit.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module control_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_valid,
    input  cpu_pkg::inst_t         inst_out,
    input  logic                   dack,
    input  logic [`CPU_DATA_W-1:0] drdata,
    output logic                   inst_take,
    output logic                   flush,
    output logic [`CPU_ADDR_W-1:0] flush_pc,
    output logic                   dreq,
    output cpu_pkg::mem_req_t      dcmd
);

    cpu_pkg::ctrl_state_e   state;
    cpu_pkg::inst_t         ir;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] b;
    logic [`CPU_DATA_W-1:0] sum;
    logic [`CPU_DATA_W-1:0] src;
    logic [`CPU_JMP_W-1:0]  jmp_target;

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    assign sum        = a + b;
    assign src        = ir.sel ? b : a;
    assign jmp_target = {ir.sel, ir.daddr};

    // pc already holds the target while flush is high
    assign flush_pc = pc;

    // ----------------------------------------
    // sequencer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= cpu_pkg::s_wait_inst;
            pc        <= '0;
            a         <= '0;
            b         <= '0;
            inst_take <= 1'b0;
            flush     <= 1'b0;
            dreq      <= 1'b0;
            dcmd      <= '0;
        end else begin
            inst_take <= 1'b0;
            flush     <= 1'b0;

            case (state)
                cpu_pkg::s_wait_inst: begin
                    if (inst_valid && !flush) begin
                        ir        <= inst_out;
                        inst_take <= 1'b1;
                        state     <= cpu_pkg::s_exec;
                    end
                end

                cpu_pkg::s_exec: begin
                    case (ir.op)
                        cpu_pkg::op_jmp: begin
                            pc    <= {{(`CPU_ADDR_W - `CPU_JMP_W){1'b0}}, jmp_target};
                            flush <= 1'b1;
                            state <= cpu_pkg::s_wait_inst;
                        end
                        cpu_pkg::op_add: begin
                            if (ir.sel) begin
                                b <= sum;
                            end else begin
                                a <= sum;
                            end
                            pc    <= pc + 1'b1;
                            state <= cpu_pkg::s_wait_inst;
                        end
                        cpu_pkg::op_ld, cpu_pkg::op_st: begin
                            dreq       <= 1'b1;
                            dcmd.addr  <= {`CPU_DATA_BASE, ir.daddr};
                            dcmd.wdata <= src;
                            dcmd.we    <= (ir.op == cpu_pkg::op_st);
                            state      <= cpu_pkg::s_wait_data;
                        end
                        default: begin
                            state <= cpu_pkg::s_wait_inst;
                        end
                    endcase
                end

                cpu_pkg::s_wait_data: begin
                    if (dreq && dack) begin
                        dreq <= 1'b0;
                        if (ir.op == cpu_pkg::op_ld) begin
                            if (ir.sel) begin
                                b <= drdata;
                            end else begin
                                a <= drdata;
                            end
                        end
                    end else if (!dreq && !dack) begin
                        // access fully closed
                        pc    <= pc + 1'b1;
                        state <= cpu_pkg::s_wait_inst;
                    end
                end

                default: begin
                    state <= cpu_pkg::s_wait_inst;
                end
            endcase
        end
    end

endmodule

/* logic/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 8

// data accesses live in the top 32 bytes
`define CPU_DATA_BASE 3'b111

// jump target is sel plus daddr
`define CPU_JMP_W 6

`endif

/* logic/cpu_pkg.sv */
`include "cpu_defines.svh"

package cpu_pkg;

    // ----------------------------------------
    // instruction encoding
    // ----------------------------------------
    typedef enum logic [1:0] {
        op_jmp = 2'b00,
        op_ld  = 2'b01,
        op_st  = 2'b10,
        op_add = 2'b11
    } opcode_e;

    // sel 0 picks a, 1 picks b
    typedef struct packed {
        opcode_e                op;
        logic                   sel;
        logic [`CPU_JMP_W-2:0]  daddr;
    } inst_t;

    // ----------------------------------------
    // memory request payload
    // ----------------------------------------
    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] wdata;
        logic                   we;
    } mem_req_t;

    typedef enum logic [1:0] {
        s_wait_inst,
        s_exec,
        s_wait_data
    } ctrl_state_e;

    typedef enum logic [1:0] {
        b_idle,
        b_fetch,
        b_data,
        b_release
    } bus_state_e;

endpackage

/* logic/data_unit.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module data_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dreq,
    input  cpu_pkg::mem_req_t      dcmd,
    input  logic                   d_ack,
    input  logic [`CPU_DATA_W-1:0] d_rdata,
    output logic                   dack,
    output logic [`CPU_DATA_W-1:0] drdata,
    output logic                   d_req,
    output cpu_pkg::mem_req_t      d_cmd
);

    logic start;
    logic done;
    logic release_req;

    // ----------------------------------------
    // handshake steps
    // ----------------------------------------

    // new access only once both sides are back to idle
    assign start = dreq && !dack && !d_req && !d_ack;

    // arbiter answered, hand the byte upstream
    assign done = d_req && d_ack && !dack;

    // upstream has the data, close both sides
    assign release_req = dack && !dreq;

    always_ff @(posedge clk) begin
        if (rst) begin
            d_req <= 1'b0;
            dack  <= 1'b0;
            d_cmd <= '0;
        end else begin
            if (start) begin
                d_req <= 1'b1;
                d_cmd <= dcmd;
            end

            if (done) begin
                dack <= 1'b1;
            end

            if (release_req) begin
                dack  <= 1'b0;
                d_req <= 1'b0;
            end
        end
    end

    // held for as long as dack is high
    always_ff @(posedge clk) begin
        if (done) begin
            drdata <= d_rdata;
        end
    end

endmodule

/* logic/eightbit_top.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module eightbit_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_ack,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,
    output logic                   mem_req,
    output cpu_pkg::mem_req_t      mem_cmd
);

    // fetch to control
    logic                   inst_valid;
    cpu_pkg::inst_t         inst_out;
    logic                   inst_take;
    logic                   flush;
    logic [`CPU_ADDR_W-1:0] flush_pc;

    // control to data unit
    logic                   dreq;
    cpu_pkg::mem_req_t      dcmd;
    logic                   dack;
    logic [`CPU_DATA_W-1:0] drdata;

    // requesters to arbiter
    logic                   f_req;
    cpu_pkg::mem_req_t      f_cmd;
    logic                   f_ack;
    logic [`CPU_DATA_W-1:0] f_rdata;
    logic                   d_req;
    cpu_pkg::mem_req_t      d_cmd;
    logic                   d_ack;
    logic [`CPU_DATA_W-1:0] d_rdata;

    control_unit control_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_out   (inst_out),
        .dack       (dack),
        .drdata     (drdata),
        .inst_take  (inst_take),
        .flush      (flush),
        .flush_pc   (flush_pc),
        .dreq       (dreq),
        .dcmd       (dcmd)
    );

    fetch_unit fetch_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .inst_take  (inst_take),
        .flush      (flush),
        .flush_pc   (flush_pc),
        .f_ack      (f_ack),
        .f_rdata    (f_rdata),
        .inst_valid (inst_valid),
        .inst_out   (inst_out),
        .f_req      (f_req),
        .f_cmd      (f_cmd)
    );

    data_unit data_unit_inst (
        .clk     (clk),
        .rst     (rst),
        .dreq    (dreq),
        .dcmd    (dcmd),
        .d_ack   (d_ack),
        .d_rdata (d_rdata),
        .dack    (dack),
        .drdata  (drdata),
        .d_req   (d_req),
        .d_cmd   (d_cmd)
    );

    bus_arbiter bus_arbiter_inst (
        .clk       (clk),
        .rst       (rst),
        .f_req     (f_req),
        .f_cmd     (f_cmd),
        .d_req     (d_req),
        .d_cmd     (d_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .f_ack     (f_ack),
        .f_rdata   (f_rdata),
        .d_ack     (d_ack),
        .d_rdata   (d_rdata),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd)
    );

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_take,
    input  logic                   flush,
    input  logic [`CPU_ADDR_W-1:0] flush_pc,
    input  logic                   f_ack,
    input  logic [`CPU_DATA_W-1:0] f_rdata,
    output logic                   inst_valid,
    output cpu_pkg::inst_t         inst_out,
    output logic                   f_req,
    output cpu_pkg::mem_req_t      f_cmd
);

    logic [`CPU_ADDR_W-1:0] fetch_ptr;
    logic [`CPU_ADDR_W-1:0] req_addr;
    logic                   buf_full;
    logic                   stale;
    cpu_pkg::inst_t         inst_q;

    // fetches are always reads
    assign f_cmd.addr  = req_addr;
    assign f_cmd.wdata = '0;
    assign f_cmd.we    = 1'b0;

    assign inst_valid = buf_full;
    assign inst_out   = inst_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_ptr <= '0;
            buf_full  <= 1'b0;
            stale     <= 1'b0;
            f_req     <= 1'b0;
        end else begin
            if (inst_take) begin
                buf_full <= 1'b0;
            end

            if (f_req && f_ack) begin
                f_req <= 1'b0;
                stale <= 1'b0;
                // data from before a flush is dropped
                if (!stale && !flush) begin
                    inst_q    <= cpu_pkg::inst_t'(f_rdata);
                    buf_full  <= 1'b1;
                    fetch_ptr <= fetch_ptr + 1'b1;
                end
            end else if (f_req && flush) begin
                stale <= 1'b1;
            end else if (!f_req && !f_ack && !buf_full && !flush) begin
                f_req    <= 1'b1;
                req_addr <= fetch_ptr;
            end

            // redirect wins over the sequential pointer update
            if (flush) begin
                buf_full  <= 1'b0;
                fetch_ptr <= flush_pc;
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, result decided from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_top -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -q "^TB PASSED$" sim.log
status=$?
if [ $status -ne 0 ]; then
    echo "pass message not found in sim.log"
    exit 1
fi

exit 0

/* verif/tb_checker.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module tb_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  int                     test_id,
    input  logic [`CPU_DATA_W-1:0] image [0:255],
    input  logic                   mem_req,
    input  cpu_pkg::mem_req_t      mem_cmd,
    input  logic                   mem_ack,
    output logic                   done,
    output int                     store_count,
    output int                     error_count,
    output int                     pass_count,
    output int                     fail_count
);

    localparam int QUIET_CYCLES = 50;
    localparam int STEP_LIMIT   = 2000;

    logic [`CPU_ADDR_W-1:0] exp_addr [$];
    logic [`CPU_DATA_W-1:0] exp_data [$];
    logic                   active = 1'b0;
    logic                   done_q = 1'b0;
    logic                   req_q = 1'b0;
    logic                   ack_q = 1'b0;
    cpu_pkg::mem_req_t      cmd_q = '0;
    int                     seen = 0;
    int                     quiet = 0;
    int                     test_errors = 0;
    int                     errors_total = 0;
    int                     tests_ok = 0;
    int                     tests_bad = 0;

    assign done        = done_q;
    assign store_count = seen;
    assign error_count = errors_total;
    assign pass_count  = tests_ok;
    assign fail_count  = tests_bad;

    // ----------------------------------------
    // ISA model, runs the image to its self-jump
    // ----------------------------------------
    function automatic void predict_stores();
        logic [7:0] m [0:255];
        logic [7:0] pc;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] ins;
        logic [7:0] addr;
        logic [7:0] target;
        logic       running;
        int         steps;
        int         i;
        exp_addr.delete();
        exp_data.delete();
        for (i = 0; i < 256; i++) begin
            m[i] = image[i];
        end
        pc      = 8'd0;
        a       = 8'd0;
        b       = 8'd0;
        running = 1'b1;
        steps   = 0;
        while (running && steps < STEP_LIMIT) begin
            ins    = m[pc];
            addr   = {`CPU_DATA_BASE, ins[4:0]};
            target = {2'b00, ins[5:0]};
            case (cpu_pkg::opcode_e'(ins[7:6]))
                cpu_pkg::op_jmp: begin
                    // jump to itself ends the program
                    if (target == pc) begin
                        running = 1'b0;
                    end
                    pc = target;
                end
                cpu_pkg::op_ld: begin
                    if (ins[5]) begin
                        b = m[addr];
                    end else begin
                        a = m[addr];
                    end
                    pc = pc + 8'd1;
                end
                cpu_pkg::op_st: begin
                    m[addr] = ins[5] ? b : a;
                    exp_addr.push_back(addr);
                    exp_data.push_back(ins[5] ? b : a);
                    pc = pc + 8'd1;
                end
                cpu_pkg::op_add: begin
                    if (ins[5]) begin
                        b = a + b;
                    end else begin
                        a = a + b;
                    end
                    pc = pc + 8'd1;
                end
            endcase
            steps++;
        end
    endfunction

    // ----------------------------------------
    // bus monitor and store comparison
    // ----------------------------------------
    always @(posedge clk) begin
        if (start) begin
            // a run cut short by reset keeps its errors
            if (active) begin
                errors_total = errors_total + test_errors;
            end
            predict_stores();
            active      = 1'b1;
            done_q      = 1'b0;
            seen        = 0;
            quiet       = 0;
            test_errors = 0;
        end else if (active && !rst) begin
            if (req_q && !mem_req && !ack_q) begin
                $display("handshake error at %0t: mem_req fell before mem_ack", $time);
                test_errors++;
            end
            if (req_q && mem_req && mem_cmd != cmd_q) begin
                $display("handshake error at %0t: mem_cmd changed while mem_req high", $time);
                test_errors++;
            end
            if (mem_req && !req_q && mem_cmd.we) begin
                if (seen >= exp_addr.size()) begin
                    $display("Fail %0t: test %0d extra store addr %h data %h",
                             $time, test_id, mem_cmd.addr, mem_cmd.wdata);
                    test_errors++;
                end else if (mem_cmd.addr != exp_addr[seen] ||
                             mem_cmd.wdata != exp_data[seen]) begin
                    $display("Fail %0t: test %0d store %0d got %h=%h, expected %h=%h",
                             $time, test_id, seen, mem_cmd.addr, mem_cmd.wdata,
                             exp_addr[seen], exp_data[seen]);
                    test_errors++;
                end
                seen++;
                quiet = 0;
            end else begin
                quiet++;
            end
            if (seen >= exp_addr.size() && quiet >= QUIET_CYCLES) begin
                if (test_errors == 0) begin
                    $display("test %0d ok: %0d stores", test_id, seen);
                    tests_ok++;
                end else begin
                    $display("test %0d bad: %0d errors", test_id, test_errors);
                    tests_bad++;
                end
                errors_total = errors_total + test_errors;
                active       = 1'b0;
                done_q       = 1'b1;
            end
        end
        req_q = mem_req;
        ack_q = mem_ack;
        cmd_q = mem_cmd;
    end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module tb_top;

    localparam int WAIT_LIMIT = 20000;

    logic                   clk;
    logic                   rst;
    logic                   mem_req;
    cpu_pkg::mem_req_t      mem_cmd;
    logic                   mem_ack = 1'b0;
    logic [`CPU_DATA_W-1:0] mem_rdata = '0;

    logic [7:0] image [0:255];
    logic [7:0] mem [0:255];
    logic       load;
    logic       start;
    logic       hung;
    int         test_id;
    int         max_delay;
    int         ack_delay = 0;
    int         ack_wait = 0;
    int         mi;

    logic       done;
    int         store_count;
    int         error_count;
    int         pass_count;
    int         fail_count;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    eightbit_top eightbit_top_inst (
        .clk       (clk),
        .rst       (rst),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd)
    );

    tb_checker checker_inst (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .test_id     (test_id),
        .image       (image),
        .mem_req     (mem_req),
        .mem_cmd     (mem_cmd),
        .mem_ack     (mem_ack),
        .done        (done),
        .store_count (store_count),
        .error_count (error_count),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    // ----------------------------------------
    // memory model, answers on falling edges
    // ----------------------------------------
    always @(negedge clk) begin
        if (load) begin
            for (mi = 0; mi < 256; mi++) begin
                mem[mi] <= image[mi];
            end
            mem_ack   <= 1'b0;
            ack_wait  <= 0;
            ack_delay <= 0;
        end else if (mem_req && !mem_ack) begin
            if (ack_wait >= ack_delay) begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem[mem_cmd.addr];
                if (mem_cmd.we) begin
                    mem[mem_cmd.addr] <= mem_cmd.wdata;
                end
                ack_wait <= 0;
            end else begin
                ack_wait <= ack_wait + 1;
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack   <= 1'b0;
            ack_delay <= int'($urandom % 32'(max_delay + 1));
        end
    end

    function automatic logic [7:0] encode(cpu_pkg::opcode_e op, logic sel, logic [4:0] field);
        return {op, sel, field};
    endfunction

    function automatic logic [7:0] encode_jmp(logic [5:0] target);
        return {cpu_pkg::op_jmp, target};
    endfunction

    task automatic clear_image();
        int i;
        for (i = 0; i < 256; i++) begin
            image[i] = 8'(i) ^ 8'h5c;
        end
    endtask

    task automatic build_directed(input int kind);
        clear_image();
        case (kind)
            // loads then stores
            0: begin
                image[0] = encode(cpu_pkg::op_ld, 1'b0, 5'h00);
                image[1] = encode(cpu_pkg::op_ld, 1'b1, 5'h01);
                image[2] = encode(cpu_pkg::op_st, 1'b0, 5'h08);
                image[3] = encode(cpu_pkg::op_st, 1'b1, 5'h09);
                image[4] = encode(cpu_pkg::op_st, 1'b1, 5'h0a);
                image[5] = encode(cpu_pkg::op_st, 1'b0, 5'h0b);
                image[6] = encode_jmp(6'd6);
                image[8'he0] = 8'h5a;
                image[8'he1] = 8'hc3;
            end
            // sums with carry out of bit 7
            1: begin
                image[0]  = encode(cpu_pkg::op_ld, 1'b0, 5'h00);
                image[1]  = encode(cpu_pkg::op_ld, 1'b1, 5'h01);
                image[2]  = encode(cpu_pkg::op_add, 1'b0, 5'h00);
                image[3]  = encode(cpu_pkg::op_st, 1'b0, 5'h08);
                image[4]  = encode(cpu_pkg::op_add, 1'b1, 5'h00);
                image[5]  = encode(cpu_pkg::op_st, 1'b1, 5'h09);
                image[6]  = encode(cpu_pkg::op_ld, 1'b0, 5'h02);
                image[7]  = encode(cpu_pkg::op_ld, 1'b1, 5'h03);
                image[8]  = encode(cpu_pkg::op_add, 1'b0, 5'h00);
                image[9]  = encode(cpu_pkg::op_st, 1'b0, 5'h0a);
                image[10] = encode_jmp(6'd10);
                image[8'he0] = 8'h90;
                image[8'he1] = 8'h85;
                image[8'he2] = 8'hff;
                image[8'he3] = 8'h01;
            end
            // skipped bytes after each jump
            2: begin
                image[0]  = encode(cpu_pkg::op_ld, 1'b0, 5'h00);
                image[1]  = encode_jmp(6'd4);
                image[2]  = encode(cpu_pkg::op_st, 1'b0, 5'h08);
                image[3]  = encode(cpu_pkg::op_st, 1'b0, 5'h09);
                image[4]  = encode(cpu_pkg::op_st, 1'b0, 5'h0a);
                image[5]  = encode(cpu_pkg::op_ld, 1'b1, 5'h01);
                image[6]  = encode_jmp(6'd9);
                image[7]  = encode(cpu_pkg::op_st, 1'b1, 5'h0b);
                image[8]  = encode(cpu_pkg::op_add, 1'b0, 5'h00);
                image[9]  = encode(cpu_pkg::op_st, 1'b1, 5'h0c);
                image[10] = encode_jmp(6'd10);
                image[8'he0] = 8'h3c;
                image[8'he1] = 8'ha7;
            end
            // first two stores show the cleared registers
            default: begin
                image[0] = encode(cpu_pkg::op_st, 1'b0, 5'h08);
                image[1] = encode(cpu_pkg::op_st, 1'b1, 5'h09);
                image[2] = encode(cpu_pkg::op_ld, 1'b0, 5'h00);
                image[3] = encode(cpu_pkg::op_ld, 1'b1, 5'h01);
                image[4] = encode(cpu_pkg::op_add, 1'b1, 5'h00);
                image[5] = encode(cpu_pkg::op_st, 1'b1, 5'h0a);
                image[6] = encode(cpu_pkg::op_st, 1'b0, 5'h0b);
                image[7] = encode_jmp(6'd7);
                image[8'he0] = 8'h11;
                image[8'he1] = 8'h22;
            end
        endcase
    endtask

    // forward jumps only, last byte jumps to itself
    task automatic build_random();
        int len;
        int i;
        int pick;
        clear_image();
        len = 8 + int'($urandom % 24);
        for (i = 0; i < len - 1; i++) begin
            pick = int'($urandom % 4);
            if (pick == 0) begin
                image[i] = encode_jmp(6'(i + 1 + int'($urandom % 32'(len - 1 - i))));
            end else begin
                image[i] = encode(cpu_pkg::opcode_e'(2'(pick)), 1'($urandom), 5'($urandom));
            end
        end
        image[len - 1] = encode_jmp(6'(len - 1));
        for (i = 224; i < 256; i++) begin
            image[i] = 8'($urandom);
        end
    endtask

    // reloads memory and arms the checker while rst is high
    task automatic restart_dut();
        @(negedge clk);
        rst  = 1'b1;
        load = 1'b1;
        repeat (3) @(negedge clk);
        load  = 1'b0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        rst   = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout waiting for test %0d to finish", test_id);
            hung = 1'b1;
        end
    endtask

    task automatic run_program(input int id, input int delay);
        test_id   = id;
        max_delay = delay;
        restart_dut();
        wait_done();
    endtask

    task automatic reset_mid_run(input int id);
        int cycles;
        build_directed(3);
        test_id   = id;
        max_delay = 3;
        restart_dut();
        cycles = 0;
        while (store_count < 3 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (store_count < 3) begin
            $display("timeout waiting for stores before the mid-run reset");
            hung = 1'b1;
        end else begin
            restart_dut();
            wait_done();
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        int round;
        int kind;
        int n;
        void'($urandom(41533));
        rst       = 1'b1;
        load      = 1'b0;
        start     = 1'b0;
        hung      = 1'b0;
        test_id   = 0;
        max_delay = 0;

        // second round reruns the directed tests under slow acks
        for (round = 0; round < 2; round++) begin
            for (kind = 0; kind < 3; kind++) begin
                if (!hung) begin
                    build_directed(kind);
                    run_program(round * 3 + kind + 1, round * 3);
                end
            end
        end
        for (n = 0; n < 20; n++) begin
            if (!hung) begin
                build_random();
                run_program(7 + n, 3);
            end
        end
        if (!hung) begin
            reset_mid_run(27);
        end

        $display("tests ok %0d, tests failed %0d, errors %0d",
                 pass_count, fail_count, error_count);
        if (hung || error_count != 0 || fail_count != 0) begin
            $display("TB FAILED");
        end else begin
            $display("TB PASSED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+logic
logic/cpu_pkg.sv
logic/fetch_unit.sv
logic/data_unit.sv
logic/bus_arbiter.sv
logic/control_unit.sv
logic/eightbit_top.sv
verif/tb_checker.sv
verif/tb_top.sv
